//--- design/xpu_pkg.sv
// register n sits at byte address 4n; only indices 0..63 decode, widths are fixed
package xpu_pkg;

  typedef logic [31:0]        reg_data_t;  // apb data word
  typedef logic [7:0]         reg_addr_t;  // apb byte address
  typedef logic [63:0]        tsf_t;       // microseconds
  typedef logic [47:0]        mac_addr_t;  // on-air byte 0 in bits 7:0
  typedef logic signed [10:0] rssi_t;      // half dB steps
  typedef logic [31:0]        fc_di_t;     // duration in 31:16, frame control in 15:0
  typedef logic [15:0]        byte_idx_t;
  typedef logic [3:0]         band_t;
  typedef logic [15:0]        channel_t;
  typedef logic [7:0]         hold_t;      // clock cycles after fcs

  // register word indices
  localparam logic [5:0] REG_SOFT_RST  = 6'd0;
  localparam logic [5:0] REG_TSF_LO    = 6'd2;
  localparam logic [5:0] REG_TSF_HI    = 6'd3;   // bit 31 rising loads the tsf
  localparam logic [5:0] REG_BAND_CH   = 6'd4;
  localparam logic [5:0] REG_CCA_HOLD  = 6'd6;
  localparam logic [5:0] REG_RSSI_TH   = 6'd8;
  localparam logic [5:0] REG_MAC_LO    = 6'd30;
  localparam logic [5:0] REG_MAC_HI    = 6'd31;
  localparam logic [5:0] REG_STATUS    = 6'd57;  // read only from here on
  localparam logic [5:0] REG_TSF_RD_LO = 6'd58;
  localparam logic [5:0] REG_TSF_RD_HI = 6'd59;
  localparam logic [5:0] REG_ADDR2_RD  = 6'd62;
  localparam logic [5:0] REG_VERSION   = 6'd63;

  // soft reset bits in REG_SOFT_RST
  localparam int SRST_PARSE_BIT = 3;
  localparam int SRST_CCA_BIT   = 6;

  localparam reg_data_t XPU_HW_REV = 32'h0b41_0100;

  // last byte of each header field, counted from the frame control
  localparam byte_idx_t FC_LAST_BYTE    = 16'd3;
  localparam byte_idx_t ADDR1_LAST_BYTE = 16'd9;
  localparam byte_idx_t ADDR2_LAST_BYTE = 16'd15;

endpackage

//--- design/xpu_cfg_if.sv
// configuration only flows from the register file outward; no clock inside, all signals levels
`timescale 1ns/1ps

interface xpu_cfg_if;

  // tsf load
  xpu_pkg::tsf_t      tsf_load_val;
  logic               tsf_load_stb;  // one cycle

  // rx header parser
  xpu_pkg::mac_addr_t mac_addr;
  logic               parse_clr;

  // channel assessment
  xpu_pkg::rssi_t     rssi_th;
  xpu_pkg::hold_t     hold_top;
  logic               cca_clr;

  modport regs_mp (
    output tsf_load_val, tsf_load_stb,
    output mac_addr, parse_clr,
    output rssi_th, hold_top, cca_clr
  );

  modport tsf_mp (
    input tsf_load_val, tsf_load_stb
  );

  modport parse_mp (
    input mac_addr, parse_clr
  );

  modport cca_mp (
    input rssi_th, hold_top, cca_clr
  );

endinterface

//--- design/xpu_regs.sv
// apb without wait states or error response; soft reset bits are levels, not self clearing
`timescale 1ns/1ps

module xpu_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  xpu_pkg::reg_addr_t  paddr_i,
  input  xpu_pkg::reg_data_t  pwdata_i,
  output xpu_pkg::reg_data_t  prdata_o,
  xpu_cfg_if.regs_mp          cfg,
  input  xpu_pkg::tsf_t       tsf_i,
  input  logic                ch_idle_i,
  input  xpu_pkg::mac_addr_t  addr2_i,
  output xpu_pkg::band_t      band_o,
  output xpu_pkg::channel_t   channel_o,
  output xpu_pkg::mac_addr_t  mac_addr_o
);

  logic [5:0]         reg_idx;
  logic               wr_en;
  xpu_pkg::reg_data_t soft_rst_q;
  xpu_pkg::reg_data_t tsf_lo_q;
  xpu_pkg::reg_data_t tsf_hi_q;
  xpu_pkg::reg_data_t band_ch_q;
  xpu_pkg::reg_data_t cca_hold_q;
  xpu_pkg::reg_data_t rssi_th_q;
  xpu_pkg::reg_data_t mac_lo_q;
  xpu_pkg::reg_data_t mac_hi_q;
  logic               tsf_msb_d;  // previous load bit
  xpu_pkg::reg_data_t rd_data;

  assign reg_idx = paddr_i[7:2];  // word aligned map
  assign wr_en   = psel_i & penable_i & pwrite_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      soft_rst_q <= '0;
      tsf_lo_q   <= '0;
      tsf_hi_q   <= '0;
      band_ch_q  <= '0;
      cca_hold_q <= '0;
      rssi_th_q  <= '0;
      mac_lo_q   <= '0;
      mac_hi_q   <= '0;
      tsf_msb_d  <= 1'b0;
    end else begin
      tsf_msb_d <= tsf_hi_q[31];
      if (wr_en) begin
        case (reg_idx)  // read-only indices fall through
          xpu_pkg::REG_SOFT_RST: soft_rst_q <= pwdata_i;
          xpu_pkg::REG_TSF_LO:   tsf_lo_q   <= pwdata_i;
          xpu_pkg::REG_TSF_HI:   tsf_hi_q   <= pwdata_i;
          xpu_pkg::REG_BAND_CH:  band_ch_q  <= pwdata_i;
          xpu_pkg::REG_CCA_HOLD: cca_hold_q <= pwdata_i;
          xpu_pkg::REG_RSSI_TH:  rssi_th_q  <= pwdata_i;
          xpu_pkg::REG_MAC_LO:   mac_lo_q   <= pwdata_i;
          xpu_pkg::REG_MAC_HI:   mac_hi_q   <= pwdata_i;
          default: ;
        endcase
      end
    end
  end

  // field decode
  assign band_o     = band_ch_q[19:16];
  assign channel_o  = band_ch_q[15:0];
  assign mac_addr_o = {mac_hi_q[15:0], mac_lo_q};

  // load fires once on the rising edge of tsf_hi bit 31
  assign cfg.tsf_load_stb = tsf_hi_q[31] & ~tsf_msb_d;
  assign cfg.tsf_load_val = {tsf_hi_q, tsf_lo_q};
  assign cfg.mac_addr     = mac_addr_o;
  assign cfg.parse_clr    = soft_rst_q[xpu_pkg::SRST_PARSE_BIT];
  assign cfg.rssi_th      = rssi_th_q[10:0];
  assign cfg.hold_top     = cca_hold_q[7:0];
  assign cfg.cca_clr      = soft_rst_q[xpu_pkg::SRST_CCA_BIT];

  always_comb begin
    case (reg_idx)
      xpu_pkg::REG_SOFT_RST:  rd_data = soft_rst_q;
      xpu_pkg::REG_TSF_LO:    rd_data = tsf_lo_q;
      xpu_pkg::REG_TSF_HI:    rd_data = tsf_hi_q;
      xpu_pkg::REG_BAND_CH:   rd_data = band_ch_q;
      xpu_pkg::REG_CCA_HOLD:  rd_data = cca_hold_q;
      xpu_pkg::REG_RSSI_TH:   rd_data = rssi_th_q;
      xpu_pkg::REG_MAC_LO:    rd_data = mac_lo_q;
      xpu_pkg::REG_MAC_HI:    rd_data = mac_hi_q;
      xpu_pkg::REG_STATUS:    rd_data = {31'd0, ch_idle_i};
      xpu_pkg::REG_TSF_RD_LO: rd_data = tsf_i[31:0];
      xpu_pkg::REG_TSF_RD_HI: rd_data = tsf_i[63:32];
      // addr2 bytes 2..5, last byte on air ends up lowest
      xpu_pkg::REG_ADDR2_RD:  rd_data = {addr2_i[23:16], addr2_i[31:24],
                                         addr2_i[39:32], addr2_i[47:40]};
      xpu_pkg::REG_VERSION:   rd_data = xpu_pkg::XPU_HW_REV;
      default:                rd_data = '0;
    endcase
  end

  assign prdata_o = (psel_i && !pwrite_i) ? rd_data : '0;

  // apb access phase must sit inside a selected transfer
  a_penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i);

endmodule

//--- design/tsf_timer.sv
// CLK_PER_US must be 1 or more; the 64-bit count is never expected to wrap
`timescale 1ns/1ps

module tsf_timer #(
  parameter int CLK_PER_US = 100
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  xpu_cfg_if.tsf_mp     cfg,
  output xpu_pkg::tsf_t tsf_o,
  output logic          tsf_pulse_1m_o
);

  localparam int               PRE_W   = $clog2(CLK_PER_US + 1);
  localparam logic [PRE_W-1:0] PRE_TOP = PRE_W'(CLK_PER_US - 1);

  logic [PRE_W-1:0] pre_cnt;  // cycles within the current microsecond
  logic             us_tick;

  assign us_tick = (pre_cnt == PRE_TOP);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pre_cnt        <= '0;
      tsf_o          <= '0;
      tsf_pulse_1m_o <= 1'b0;
    end else if (cfg.tsf_load_stb) begin
      // load wins over a tick on the same edge
      pre_cnt        <= '0;
      tsf_o          <= cfg.tsf_load_val;
      tsf_pulse_1m_o <= 1'b0;
    end else begin
      pre_cnt        <= us_tick ? '0 : pre_cnt + 1'b1;
      tsf_o          <= tsf_o + us_tick;
      tsf_pulse_1m_o <= us_tick;  // marks the increment edge
    end
  end

  // only a register load may move the tsf backwards
  a_tsf_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) && !$past(cfg.tsf_load_stb) |-> tsf_o >= $past(tsf_o));

endmodule

//--- design/rx_mac_parse.sv
// byte_count_i starts at 0 on the frame control byte; fields past addr2 are ignored
`timescale 1ns/1ps

module rx_mac_parse (
  input  logic               clk_i,
  input  logic               rst_n_i,
  xpu_cfg_if.parse_mp        cfg,
  input  logic               pkt_header_valid_strobe_i,
  input  logic               byte_in_strobe_i,
  input  logic [7:0]         byte_in_i,
  input  xpu_pkg::byte_idx_t byte_count_i,
  output xpu_pkg::fc_di_t    fc_di_o,
  output logic               fc_di_valid_o,
  output xpu_pkg::mac_addr_t addr1_o,
  output logic               addr1_valid_o,
  output xpu_pkg::mac_addr_t addr2_o,
  output logic               addr2_valid_o,
  output logic               pkt_for_me_o
);

  logic [2:0] addr1_pos;  // byte slot inside addr1
  logic [2:0] addr2_pos;
  logic       hdr_clr;

  assign addr1_pos = 3'(byte_count_i - (xpu_pkg::FC_LAST_BYTE + 1));
  assign addr2_pos = 3'(byte_count_i - (xpu_pkg::ADDR1_LAST_BYTE + 1));
  assign hdr_clr   = pkt_header_valid_strobe_i | cfg.parse_clr;

  // payload, byte placed by its index, first on air lowest
  always_ff @(posedge clk_i) begin
    if (byte_in_strobe_i) begin
      if (byte_count_i <= xpu_pkg::FC_LAST_BYTE) begin
        fc_di_o[8*byte_count_i[1:0] +: 8] <= byte_in_i;
      end else if (byte_count_i <= xpu_pkg::ADDR1_LAST_BYTE) begin
        addr1_o[8*addr1_pos +: 8] <= byte_in_i;
      end else if (byte_count_i <= xpu_pkg::ADDR2_LAST_BYTE) begin
        addr2_o[8*addr2_pos +: 8] <= byte_in_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fc_di_valid_o <= 1'b0;
      addr1_valid_o <= 1'b0;
      addr2_valid_o <= 1'b0;
    end else if (hdr_clr) begin
      // new frame or soft reset
      fc_di_valid_o <= 1'b0;
      addr1_valid_o <= 1'b0;
      addr2_valid_o <= 1'b0;
    end else if (byte_in_strobe_i) begin
      if (byte_count_i == xpu_pkg::FC_LAST_BYTE) begin
        fc_di_valid_o <= 1'b1;
      end
      if (byte_count_i == xpu_pkg::ADDR1_LAST_BYTE) begin
        addr1_valid_o <= 1'b1;
      end
      if (byte_count_i == xpu_pkg::ADDR2_LAST_BYTE) begin
        addr2_valid_o <= 1'b1;
      end
    end
  end

  assign pkt_for_me_o = addr1_valid_o && (addr1_o == cfg.mac_addr);

  // bytes arrive in order, so addr2 cannot complete before addr1
  a_addr_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    addr2_valid_o |-> addr1_valid_o);

endmodule

//--- design/cca.sv
// rssi compare is signed; the fcs cycle itself already counts as busy
`timescale 1ns/1ps

module cca (
  input  logic           clk_i,
  input  logic           rst_n_i,
  xpu_cfg_if.cca_mp      cfg,
  input  xpu_pkg::rssi_t rssi_half_db_i,
  input  logic           demod_is_ongoing_i,
  input  logic           tx_rf_is_ongoing_i,
  input  logic           fcs_in_strobe_i,
  output logic           ch_idle_o
);

  xpu_pkg::hold_t hold_cnt;  // post-fcs quiet time
  logic           busy;

  assign busy = (rssi_half_db_i > cfg.rssi_th)
              | demod_is_ongoing_i
              | tx_rf_is_ongoing_i
              | fcs_in_strobe_i
              | (hold_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_cnt  <= '0;
      ch_idle_o <= 1'b0;
    end else begin
      if (cfg.cca_clr) begin
        hold_cnt <= '0;
      end else if (fcs_in_strobe_i) begin
        hold_cnt <= cfg.hold_top;  // restart on each fcs
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      ch_idle_o <= ~busy;
    end
  end

  // a running hold always follows a busy cycle
  a_hold_blocks_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hold_cnt != '0) |-> !ch_idle_o);

endmodule

//--- design/xpu.sv
// single clock domain; apb has no wait states and the rx byte stream is never stalled
`timescale 1ns/1ps

module xpu #(
  parameter int CLK_PER_US = 100
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // apb slave
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  xpu_pkg::reg_addr_t paddr_i,
  input  xpu_pkg::reg_data_t pwdata_i,
  output xpu_pkg::reg_data_t prdata_o,
  // demodulated rx stream
  input  logic               pkt_header_valid_strobe_i,
  input  logic               byte_in_strobe_i,
  input  logic [7:0]         byte_in_i,
  input  xpu_pkg::byte_idx_t byte_count_i,
  input  logic               fcs_in_strobe_i,
  // channel activity
  input  xpu_pkg::rssi_t     rssi_half_db_i,
  input  logic               demod_is_ongoing_i,
  input  logic               tx_rf_is_ongoing_i,
  // outputs
  output xpu_pkg::band_t     band_o,
  output xpu_pkg::channel_t  channel_o,
  output xpu_pkg::mac_addr_t mac_addr_o,
  output xpu_pkg::tsf_t      tsf_o,
  output logic               tsf_pulse_1m_o,
  output xpu_pkg::fc_di_t    fc_di_o,
  output logic               fc_di_valid_o,
  output xpu_pkg::mac_addr_t addr1_o,
  output logic               addr1_valid_o,
  output xpu_pkg::mac_addr_t addr2_o,
  output logic               addr2_valid_o,
  output logic               pkt_for_me_o,
  output logic               ch_idle_o
);

  xpu_cfg_if cfg ();

  xpu_regs i_regs (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .cfg(cfg.regs_mp),
    .tsf_i(tsf_o), .ch_idle_i(ch_idle_o), .addr2_i(addr2_o),  // status back
    .band_o(band_o), .channel_o(channel_o), .mac_addr_o(mac_addr_o)
  );

  tsf_timer #(.CLK_PER_US(CLK_PER_US)) i_tsf (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg.tsf_mp),
    .tsf_o(tsf_o), .tsf_pulse_1m_o(tsf_pulse_1m_o)
  );

  rx_mac_parse i_parse (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg.parse_mp),
    .pkt_header_valid_strobe_i(pkt_header_valid_strobe_i),
    .byte_in_strobe_i(byte_in_strobe_i), .byte_in_i(byte_in_i), .byte_count_i(byte_count_i),
    .fc_di_o(fc_di_o), .fc_di_valid_o(fc_di_valid_o),
    .addr1_o(addr1_o), .addr1_valid_o(addr1_valid_o),
    .addr2_o(addr2_o), .addr2_valid_o(addr2_valid_o),
    .pkt_for_me_o(pkt_for_me_o)
  );

  cca i_cca (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg.cca_mp),
    .rssi_half_db_i(rssi_half_db_i), .demod_is_ongoing_i(demod_is_ongoing_i),
    .tx_rf_is_ongoing_i(tx_rf_is_ongoing_i), .fcs_in_strobe_i(fcs_in_strobe_i),
    .ch_idle_o(ch_idle_o)
  );

endmodule

//--- tb/tb_xpu.sv
// cases come from tb/xpu_cases.txt; CLK_PER_US is 10 so one microsecond is ten clocks
`timescale 1ns/1ps

module tb_xpu;

  logic               clk_i = 1'b0;
  logic               rst_n_i;
  logic               psel_i, penable_i, pwrite_i;
  xpu_pkg::reg_addr_t paddr_i;
  xpu_pkg::reg_data_t pwdata_i, prdata_o;
  logic               pkt_header_valid_strobe_i, byte_in_strobe_i, fcs_in_strobe_i;
  logic [7:0]         byte_in_i;
  xpu_pkg::byte_idx_t byte_count_i;
  xpu_pkg::rssi_t     rssi_half_db_i;
  logic               demod_is_ongoing_i, tx_rf_is_ongoing_i;
  xpu_pkg::band_t     band_o;
  xpu_pkg::channel_t  channel_o;
  xpu_pkg::mac_addr_t mac_addr_o, addr1_o, addr2_o;
  xpu_pkg::tsf_t      tsf_o;
  xpu_pkg::fc_di_t    fc_di_o;
  logic               tsf_pulse_1m_o, fc_di_valid_o, addr1_valid_o, addr2_valid_o;
  logic               pkt_for_me_o, ch_idle_o;

  integer             seed = 32'hfcf04774;
  int                 n_cases = 0;
  logic signed [10:0] th_shadow = '0;  // last rssi threshold written
  logic [31:0]        mac_lo_shadow = '0;
  logic [31:0]        mac_hi_shadow = '0;

  xpu #(.CLK_PER_US(10)) i_dut (.*);

  always #50 clk_i = ~clk_i;

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    pwrite_i  <= 1'b1;
    penable_i <= 1'b0;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);  // access edge
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    if (addr == {xpu_pkg::REG_RSSI_TH, 2'b00}) th_shadow = data[10:0];
    if (addr == {xpu_pkg::REG_MAC_LO, 2'b00}) mac_lo_shadow = data;
    if (addr == {xpu_pkg::REG_MAC_HI, 2'b00}) mac_hi_shadow = data;
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    pwrite_i  <= 1'b0;
    penable_i <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check(64'(prdata_o), 64'(exp), $sformatf("read of address %h", addr));
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic write_and_decode(input logic [7:0] addr, input logic [31:0] data);
    apb_write(addr, data);
    @(negedge clk_i);
    if (addr == {xpu_pkg::REG_BAND_CH, 2'b00}) begin
      check(64'(band_o), 64'(data[19:16]), "band decode");
      check(64'(channel_o), 64'(data[15:0]), "channel decode");
    end
    check(64'(mac_addr_o), 64'({mac_hi_shadow[15:0], mac_lo_shadow}), "mac address decode");
  endtask

  task automatic pulse_header_strobe();
    @(posedge clk_i);
    pkt_header_valid_strobe_i <= 1'b1;
    @(posedge clk_i);
    pkt_header_valid_strobe_i <= 1'b0;
    @(negedge clk_i);
    check(64'({fc_di_valid_o, addr1_valid_o, addr2_valid_o}), 64'd0, "valids after header");
  endtask

  task automatic stream_header_bytes(input logic [127:0] frame);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk_i);
      byte_in_strobe_i <= 1'b1;
      byte_in_i        <= frame[8*i +: 8];
      byte_count_i     <= 16'(i);
    end
    @(posedge clk_i);
    byte_in_strobe_i <= 1'b0;
    @(negedge clk_i);
    check(64'({fc_di_valid_o, addr1_valid_o, addr2_valid_o}), 64'd7, "valids after frame");
  endtask

  task automatic send_frame(input logic [31:0] fc, input logic [47:0] a1,
                            input logic [47:0] a2, input logic for_me);
    logic [127:0] frame;
    logic [31:0]  a2_rd;
    frame = {32'd0, a2, a1, fc};  // first byte on air lowest
    pulse_header_strobe();
    stream_header_bytes(frame);
    check(64'(fc_di_o), 64'(fc), "frame control and duration");
    check(64'(addr1_o), 64'(a1), "addr1");
    check(64'(addr2_o), 64'(a2), "addr2");
    check(64'(pkt_for_me_o), 64'(for_me), "pkt_for_me");
    // bytes 2..5 of addr2, byte 5 in the low lane
    for (int k = 2; k < 6; k++) begin
      a2_rd[8*(5-k) +: 8] = a2[8*k +: 8];
    end
    apb_read({xpu_pkg::REG_ADDR2_RD, 2'b00}, a2_rd);
    // next header drops the valids, then the same header again
    pulse_header_strobe();
    stream_header_bytes(frame);
  endtask

  task automatic random_cca(input int samples, input logic demod, input logic tx);
    logic [31:0]        r;
    logic signed [10:0] rssi;
    for (int i = 0; i < samples; i++) begin
      r    = $random(seed);
      rssi = r[10:0];
      @(posedge clk_i);
      rssi_half_db_i     <= rssi;
      demod_is_ongoing_i <= demod;
      tx_rf_is_ongoing_i <= tx;
      @(posedge clk_i);
      @(negedge clk_i);
      check(64'(ch_idle_o), 64'(!demod && !tx && (rssi <= th_shadow)), "channel idle");
    end
    @(posedge clk_i);
    rssi_half_db_i     <= '0;
    demod_is_ongoing_i <= 1'b0;
    tx_rf_is_ongoing_i <= 1'b0;
  endtask

  task automatic fcs_hold(input int hold);
    apb_write({xpu_pkg::REG_CCA_HOLD, 2'b00}, 32'(hold));
    @(posedge clk_i);
    fcs_in_strobe_i <= 1'b1;
    @(posedge clk_i);
    fcs_in_strobe_i <= 1'b0;
    for (int i = 0; i <= hold; i++) begin
      @(negedge clk_i);
      check(64'(ch_idle_o), 64'd0, "idle during fcs hold");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check(64'(ch_idle_o), 64'd1, "idle after fcs hold");
  endtask

  task automatic soft_reset(input logic [31:0] value);
    if (value[xpu_pkg::SRST_CCA_BIT]) begin
      @(posedge clk_i);
      fcs_in_strobe_i <= 1'b1;
      @(posedge clk_i);
      fcs_in_strobe_i <= 1'b0;
    end
    apb_write({xpu_pkg::REG_SOFT_RST, 2'b00}, value);
    if (value[xpu_pkg::SRST_PARSE_BIT]) begin
      @(posedge clk_i);  // clear reaches the parser one cycle after the write
      @(negedge clk_i);
      check(64'({fc_di_valid_o, addr1_valid_o, addr2_valid_o}), 64'd0, "parse soft reset");
    end
    if (value[xpu_pkg::SRST_CCA_BIT]) begin
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      check(64'(ch_idle_o), 64'd1, "cca soft reset");
    end
    apb_write({xpu_pkg::REG_SOFT_RST, 2'b00}, 32'd0);
  endtask

  task automatic tsf_load(input logic [63:0] load, input int wait_cycles);
    int pulses;
    pulses = 0;
    apb_write({xpu_pkg::REG_TSF_HI, 2'b00}, 32'd0);  // arm the rising edge
    apb_write({xpu_pkg::REG_TSF_LO, 2'b00}, load[31:0]);
    apb_write({xpu_pkg::REG_TSF_HI, 2'b00}, load[63:32]);
    repeat (wait_cycles) begin
      @(posedge clk_i);
      @(negedge clk_i);
      if (tsf_pulse_1m_o) pulses++;
    end
    check(64'(pulses), 64'((wait_cycles - 1) / 10), "1 MHz pulse count");
    check(tsf_o, load + 64'((wait_cycles - 1) / 10), "tsf output");
    apb_read({xpu_pkg::REG_TSF_RD_LO, 2'b00}, load[31:0] + 32'((wait_cycles + 1) / 10));
    apb_read({xpu_pkg::REG_TSF_RD_HI, 2'b00}, load[63:32]);
  endtask

  initial begin
    wait (n_cases > 0);
    #(n_cases * 200 * 100 + 100000);
    $display("timeout, the case list did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog");
  end

  initial begin
    integer      fd;
    integer      n;
    string       line;
    string       lines[$];
    byte         op;
    logic [63:0] f1, f2, f3, f4;
    rst_n_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    pkt_header_valid_strobe_i = 1'b0;
    byte_in_strobe_i = 1'b0;
    fcs_in_strobe_i = 1'b0;
    byte_in_i = '0;
    byte_count_i = '0;
    rssi_half_db_i = '0;
    demod_is_ongoing_i = 1'b0;
    tx_rf_is_ongoing_i = 1'b0;
    fd = $fopen("tb/xpu_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/xpu_cases.txt");
      $display("Result: FAILED");
      $fatal(1, "no case file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") lines.push_back(line);
    end
    $fclose(fd);
    n_cases = lines.size();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (lines[i]) begin
      n = $sscanf(lines[i], "%c", op);
      case (op)
        "W": begin
          n = $sscanf(lines[i], "%c %h %h", op, f1, f2);
          write_and_decode(f1[7:0], f2[31:0]);
        end
        "R": begin
          n = $sscanf(lines[i], "%c %h %h", op, f1, f2);
          apb_read(f1[7:0], f2[31:0]);
        end
        "F": begin
          n = $sscanf(lines[i], "%c %h %h %h %h", op, f1, f2, f3, f4);
          send_frame(f1[31:0], f2[47:0], f3[47:0], f4[0]);
        end
        "C": begin
          n = $sscanf(lines[i], "%c %d %d %d", op, f1, f2, f3);
          random_cca(int'(f1), f2[0], f3[0]);
        end
        "H": begin
          n = $sscanf(lines[i], "%c %d", op, f1);
          fcs_hold(int'(f1));
        end
        "S": begin
          n = $sscanf(lines[i], "%c %h", op, f1);
          soft_reset(f1[31:0]);
        end
        "T": begin
          n = $sscanf(lines[i], "%c %h %d", op, f1, f2);
          tsf_load(f1, int'(f2));
        end
        default: begin
          $display("unknown operation in case line: %s", lines[i]);
          $display("Result: FAILED");
          $fatal(1, "bad case line");
        end
      endcase
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- build.f
design/xpu_pkg.sv
design/xpu_cfg_if.sv
design/xpu_regs.sv
design/tsf_timer.sv
design/rx_mac_parse.sv
design/cca.sv
design/xpu.sv
tb/tb_xpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the xpu testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f build.f --top-module tb_xpu -o tb_xpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_xpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tb/xpu_cases.txt
# op fields: W addr data | R addr exp | F fc addr1 addr2 for_me | S soft_rst (all hex)
# C samples demod tx | H hold | T load_hex wait_cycles (counts in decimal)
R fc 0b410100
R 40 00000000
W 10 00030024
R 10 00030024
W 20 00000028
R 20 00000028
W 78 33221100
W 7c 00005544
R 7c 00005544
W e4 ffffffff
R e4 00000001
F 002c0088 554433221100 aabbccddeeff 1
S 00000008
F 00000040 ffffffffffff 0a0b0c0d0e0f 0
C 20 0 0
C 4 1 0
C 4 0 1
H 5
H 12
W 18 000000c8
R 18 000000c8
S 00000040
T 8000000000001000 25
T 800000010000ff00 97
